//--- si5338_cfg_top.f
source/si5338_reg_pkg.sv
source/cfg_seq_pkg.sv
source/ms_param_regs.sv
source/cfg_sequencer.sv
source/si5338_cfg_top.sv
testbench/si5338_cfg_asserts.sv
testbench/si5338_cfg_tb.sv

//--- testbench/si5338_cfg_tb.sv
`timescale 1ns/1ps

module si5338_cfg_tb;
	import si5338_reg_pkg::*;

	localparam int CLK_PERIOD = 100;               // ns
	localparam int MS_P1 = 2150;                   // Divider values under test
	localparam int MS_P2 = 32;
	localparam int MS_P3 = 100;
	localparam int BASE_ADDR = 75;                 // MultiSynth 2 block
	localparam int NWRITES = 10;                   // Bytes per parameter block
	localparam int NROWS = 6;
	localparam int RAND_BUSY_MAX = 6;              // Upper bound of random busy delay
	localparam int RAND_DONE_MAX = 4;              // Upper bound of random done delay
	localparam int START_WAIT = 8;                 // Cycles allowed for start to show up

	// One full configuration run per row
	typedef struct packed
	{
		int busy;                                  // Cycles with busy before done
		int done;                                  // Cycles with done high
		int gap;                                   // Idle cycles before enable
		bit rnd;                                   // Delays drawn per write
		bit re_en;                                 // Pulse enable during write 5
	} row_t;

	row_t stim [NROWS] = '{
		'{1, 1, 3, 1'b0, 1'b0},                    // Fastest controller
		'{3, 2, 0, 1'b0, 1'b1},                    // Back to back, enable mid-run
		'{20, 1, 2, 1'b0, 1'b0},                   // Long busy
		'{2, 12, 1, 1'b0, 1'b0},                   // Long done level
		'{0, 0, 0, 1'b1, 1'b1},                    // Random delays
		'{0, 0, 5, 1'b1, 1'b0}
	};

	logic      iCLK;
	logic      iRST_n;
	logic      enable;
	logic      i2c_busy;
	logic      i2c_done;
	reg_byte_t byte_addr;
	reg_byte_t byte_data;
	logic      start;
	logic      ready;
	logic      cfg_done;

	int          errors;
	int          tests_failed;
	int          done_pulses = 0;                  // cfg_done cycles seen so far
	logic [31:0] rng;

	si5338_cfg_top si5338_cfg_top_inst
	(
		.iCLK      (iCLK),
		.iRST_n    (iRST_n),
		.enable    (enable),
		.i2c_busy  (i2c_busy),
		.i2c_done  (i2c_done),
		.byte_addr (byte_addr),
		.byte_data (byte_data),
		.start     (start),
		.ready     (ready),
		.cfg_done  (cfg_done)
	);

	// ===========================================================================
	// Clock and completion pulse monitor
	// ===========================================================================

	initial
	begin
		iCLK = 1'b0;
		forever #(CLK_PERIOD / 2) iCLK = ~iCLK;
	end

	always @(negedge iCLK)
	begin
		if (cfg_done === 1'b1)
			done_pulses++;
	end

	// ===========================================================================
	// Reference model of the register image
	// ===========================================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Ten bytes laid out LSB first, P1 then P2 then P3, two spare bits on top
	function automatic logic [7:0] exp_data(input int w);
		logic [79:0] block;
		block = {2'b00, MS_P3[29:0], MS_P2[29:0], MS_P1[17:0]};
		return block[(w - 1) * 8 +: 8];
	endfunction

	function automatic logic [7:0] exp_addr(input int w);
		return 8'(BASE_ADDR + w - 1);
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic report_test(input int num, input string label, input int err_before);
		if (errors == err_before)
			$display("Test %0d (%s): ok", num, label);
		else
		begin
			tests_failed++;
			$display("Test %0d (%s): %0d check errors", num, label, errors - err_before);
		end
	endtask

	// ===========================================================================
	// I2C byte controller model, one write
	// ===========================================================================

	task automatic hold_checks(input int cycles, input reg_byte_t addr, input reg_byte_t data);
		repeat (cycles)
		begin
			@(negedge iCLK);
			check_val("start", start, 0);                // Back-pressure
			check_val("byte_addr", byte_addr, addr);     // Stable until advance
			check_val("byte_data", byte_data, data);
			check_val("ready", ready, 0);
		end
	endtask

	task automatic serve_write(input int w, input int busy_cyc, input int done_cyc, input bit re_en);
		int n;
		reg_byte_t addr;
		reg_byte_t data;
		n = 0;
		@(negedge iCLK);
		while (start !== 1'b1 && n < START_WAIT)
		begin
			check_val("ready", ready, 0);
			@(negedge iCLK);
			n++;
		end
		if (start !== 1'b1)
		begin
			errors++;
			$display("Write %0d: the sequencer never raised start", w);
			return;
		end
		addr = byte_addr;                              // Captured on accept
		data = byte_data;
		check_val("byte_addr", addr, exp_addr(w));
		check_val("byte_data", data, exp_data(w));
		check_val("ready", ready, 0);
		@(posedge iCLK);
		i2c_busy <= 1'b1;
		if (re_en)
			enable <= 1'b1;                            // Must not restart the run
		hold_checks(busy_cyc, addr, data);
		@(posedge iCLK);
		i2c_done <= 1'b1;
		enable <= 1'b0;
		hold_checks(done_cyc, addr, data);
		@(posedge iCLK);
		i2c_busy <= 1'b0;
		i2c_done <= 1'b0;
		hold_checks(1, addr, data);                    // Edge not yet taken
	endtask

	task automatic run_row(input int r);
		int row_err;
		int pulses_before;
		int busy_cyc;
		int done_cyc;
		row_err = errors;
		repeat (stim[r].gap)
		begin
			@(negedge iCLK);
			check_val("start", start, 0);                // No write without enable
			check_val("ready", ready, 1);
		end
		@(posedge iCLK);
		enable <= 1'b1;
		pulses_before = done_pulses;
		@(posedge iCLK);
		enable <= 1'b0;
		for (int w = 1; w <= NWRITES; w++)
		begin
			busy_cyc = stim[r].busy;
			done_cyc = stim[r].done;
			if (stim[r].rnd)
			begin
				rng = xorshift32(rng);
				busy_cyc = 1 + int'(rng % RAND_BUSY_MAX);
				rng = xorshift32(rng);
				done_cyc = 1 + int'(rng % RAND_DONE_MAX);
			end
			serve_write(w, busy_cyc, done_cyc, stim[r].re_en && w == 5);
		end
		@(negedge iCLK);
		check_val("cfg_done", cfg_done, 1);            // Cycle after the tenth edge
		check_val("ready", ready, 1);
		check_val("start", start, 0);
		@(negedge iCLK);
		check_val("cfg_done", cfg_done, 0);
		@(posedge iCLK);
		check_val("cfg_done pulses", done_pulses - pulses_before, 1);
		report_test(r + 1, $sformatf("busy %0d done %0d gap %0d rnd %0d re_en %0d",
			stim[r].busy, stim[r].done, stim[r].gap, stim[r].rnd, stim[r].re_en), row_err);
	endtask

	// ===========================================================================
	// Main sequence
	// ===========================================================================

	initial
	begin
		int row_err;
		int sva_err;
		iRST_n = 1'b0;
		enable = 1'b0;
		i2c_busy = 1'b0;
		i2c_done = 1'b0;
		errors = 0;
		tests_failed = 0;
		rng = 32'd6;                                   // Seed
		repeat (2) @(posedge iCLK);
		iRST_n <= 1'b1;
		row_err = errors;
		repeat (6)
		begin
			@(negedge iCLK);
			check_val("start", start, 0);
			check_val("cfg_done", cfg_done, 0);
			check_val("ready", ready, 1);
		end
		report_test(0, "reset and idle", row_err);
		for (int r = 0; r < NROWS; r++)
			run_row(r);
		@(negedge iCLK);                               // Last assertion actions are done
		sva_err = si5338_cfg_top_inst.cfg_sequencer_inst.si5338_cfg_asserts_inst.failures;
		$display("Tests run: %0d, tests with errors: %0d, check errors: %0d, assertions: %0d",
			NROWS + 1, tests_failed, errors, sva_err);
		if (errors == 0 && sva_err == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// Watchdog sized from the slowest row
	initial
	begin
		int worst;
		int cur;
		int gap_max;
		int limit;
		worst = 0;
		gap_max = 0;
		for (int r = 0; r < NROWS; r++)
		begin
			cur = stim[r].rnd ? RAND_BUSY_MAX + RAND_DONE_MAX : stim[r].busy + stim[r].done;
			if (cur > worst)
				worst = cur;
			if (stim[r].gap > gap_max)
				gap_max = stim[r].gap;
		end
		limit = (NROWS + 1) * NWRITES * (worst + START_WAIT + 4) + NROWS * gap_max + 100;
		#(limit * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not finish", limit);
		$display("Test failures found");
		$finish;
	end

endmodule

//--- testbench/si5338_cfg_asserts.sv
`timescale 1ns/1ps

module si5338_cfg_asserts
(
	input logic               iCLK,
	input logic               iRST_n,
	input logic               i2c_busy,
	input logic               start,
	input logic               ready,
	input logic               cfg_done,
	input cfg_seq_pkg::step_t step
);
	import cfg_seq_pkg::*;

	int failures = 0;                              // Failed assertions so far

	// ===========================================================================
	// Handshake rules
	// ===========================================================================

	// No new request while the controller is on the bus
	assert property (@(posedge iCLK) disable iff (!iRST_n) i2c_busy |-> !start)
		else
		begin
			failures++;
			$error("start high while i2c_busy is high");
		end

	// Completion is a single clock
	assert property (@(posedge iCLK) disable iff (!iRST_n) cfg_done |=> !cfg_done)
		else
		begin
			failures++;
			$error("cfg_done held for more than one cycle");
		end

	// Busy sequencer never reports ready
	assert property (@(posedge iCLK) disable iff (!iRST_n) (step != STEP_IDLE) |-> !ready)
		else
		begin
			failures++;
			$error("ready high while a step is active");
		end

endmodule

bind cfg_sequencer si5338_cfg_asserts si5338_cfg_asserts_inst
(
	.iCLK     (iCLK),
	.iRST_n   (iRST_n),
	.i2c_busy (i2c_busy),
	.start    (start),
	.ready    (ready),
	.cfg_done (cfg_done),
	.step     (step)
);

//--- source/si5338_cfg_top.sv
`timescale 1ns/1ps

module si5338_cfg_top
#(
	parameter si5338_reg_pkg::reg_byte_t MS_BASE_ADDR = si5338_reg_pkg::MS2_BASE_ADDR,
	parameter logic [si5338_reg_pkg::MS_P1_W-1:0] MS_P1 = 2150,   // 125 MHz from 2.6 GHz VCO
	parameter logic [si5338_reg_pkg::MS_P23_W-1:0] MS_P2 = 32,
	parameter logic [si5338_reg_pkg::MS_P23_W-1:0] MS_P3 = 100
)
(
	input  logic                      iCLK,
	input  logic                      iRST_n,
	input  logic                      enable,        // Start a configuration run
	input  logic                      i2c_busy,      // From the I2C byte controller
	input  logic                      i2c_done,      // From the I2C byte controller
	output si5338_reg_pkg::reg_byte_t byte_addr,     // Register address to write
	output si5338_reg_pkg::reg_byte_t byte_data,     // Register value to write
	output logic                      start,         // Write request
	output logic                      ready,         // Sequencer idle
	output logic                      cfg_done       // Run finished
);
	import cfg_seq_pkg::*;

	step_t step;                                     // Current write index

	// ===========================================================================
	// Handshake and step counter
	// ===========================================================================

	cfg_sequencer cfg_sequencer_inst
	(
		.iCLK     (iCLK),
		.iRST_n   (iRST_n),
		.enable   (enable),
		.i2c_busy (i2c_busy),
		.i2c_done (i2c_done),
		.step     (step),
		.start    (start),
		.ready    (ready),
		.cfg_done (cfg_done)
	);

	// ===========================================================================
	// MultiSynth register image
	// ===========================================================================

	ms_param_regs
	#(
		.MS_BASE_ADDR (MS_BASE_ADDR),
		.MS_P1        (MS_P1),
		.MS_P2        (MS_P2),
		.MS_P3        (MS_P3)
	)
	ms_param_regs_inst
	(
		.step      (step),
		.byte_addr (byte_addr),
		.byte_data (byte_data)
	);

endmodule

//--- source/cfg_sequencer.sv
`timescale 1ns/1ps

module cfg_sequencer
(
	input  logic               iCLK,
	input  logic               iRST_n,
	input  logic               enable,            // Request a run, honoured when idle
	input  logic               i2c_busy,          // Controller is on the bus
	input  logic               i2c_done,          // Controller completion level
	output cfg_seq_pkg::step_t step,              // Current write index
	output logic               start,             // Present the byte pair to the controller
	output logic               ready,             // High while idle
	output logic               cfg_done           // One clock after the last write
);
	import cfg_seq_pkg::*;

	logic done_d;                                 // i2c_done one clock late
	logic done_fall;                              // Controller finished one write
	logic step_active;                            // A run is in progress
	logic seq_end;                                // Last write has completed

	// ===========================================================================
	// Completion edge of the controller
	// ===========================================================================

	always_ff @(posedge iCLK or negedge iRST_n)
	begin
		if (!iRST_n)
			done_d <= 1'b0;
		else
			done_d <= i2c_done;
	end

	assign done_fall = done_d & ~i2c_done;        // High then low
	assign step_active = (step != STEP_IDLE);
	assign seq_end = done_fall & (step == LAST_STEP);

	// ===========================================================================
	// Step counter
	// ===========================================================================

	always_ff @(posedge iCLK or negedge iRST_n)
	begin
		if (!iRST_n)
			step <= STEP_IDLE;
		else if (!step_active)
		begin
			if (enable)
				step <= FIRST_STEP;                       // Enable mid-run is ignored
		end
		else if (seq_end)
			step <= STEP_IDLE;                          // Back to idle after the tenth write
		else if (done_fall)
			step <= step + step_t'(1);                  // Next register
	end

	// Request a write only once the controller has fully released
	// busy and done, so a pending edge never re-issues the old byte pair
	assign start = step_active & ~(i2c_busy | i2c_done | done_d);

	// ===========================================================================
	// Status flags
	// ===========================================================================

	always_ff @(posedge iCLK or negedge iRST_n)
	begin
		if (!iRST_n)
			ready <= 1'b1;                              // Idle out of reset
		else if (!step_active && enable)
			ready <= 1'b0;                              // Drops with the first step
		else if (seq_end)
			ready <= 1'b1;
	end

	always_ff @(posedge iCLK or negedge iRST_n)
	begin
		if (!iRST_n)
			cfg_done <= 1'b0;
		else
			cfg_done <= seq_end;                        // Single clock pulse
	end

endmodule

//--- source/ms_param_regs.sv
`timescale 1ns/1ps

module ms_param_regs
#(
	parameter si5338_reg_pkg::reg_byte_t MS_BASE_ADDR = si5338_reg_pkg::MS2_BASE_ADDR,
	parameter logic [si5338_reg_pkg::MS_P1_W-1:0] MS_P1 = 2150,
	parameter logic [si5338_reg_pkg::MS_P23_W-1:0] MS_P2 = 32,
	parameter logic [si5338_reg_pkg::MS_P23_W-1:0] MS_P3 = 100
)
(
	input  cfg_seq_pkg::step_t        step,       // Current write, 0 when idle
	output si5338_reg_pkg::reg_byte_t byte_addr,  // Register address for this write
	output si5338_reg_pkg::reg_byte_t byte_data   // Register value for this write
);
	import si5338_reg_pkg::*;
	import cfg_seq_pkg::*;

	reg_byte_t step_off;                           // Offset into the block
	reg_byte_t addr_c;
	reg_byte_t data_c;

	// ===========================================================================
	// Address of the current write
	// ===========================================================================

	always_comb
	begin
		step_off = reg_byte_t'(step) - 8'd1;          // Step 1 is the base register
		if (step == STEP_IDLE || step > LAST_STEP)
			addr_c = 8'd0;                              // Nothing to write
		else
			addr_c = MS_BASE_ADDR + step_off;
	end

	// ===========================================================================
	// Data byte of the current write
	// ===========================================================================

	always_comb
	begin
		case (step)
			4'd1:
				data_c = MS_P1[7:0];                      // P1 low byte
			4'd2:
				data_c = MS_P1[15:8];                     // P1 middle byte
			4'd3:
				data_c = {MS_P2[5:0], MS_P1[17:16]};      // P2 low bits over P1 top
			4'd4:
				data_c = MS_P2[13:6];
			4'd5:
				data_c = MS_P2[21:14];
			4'd6:
				data_c = MS_P2[29:22];                    // P2 top byte
			4'd7:
				data_c = MS_P3[7:0];                      // P3 low byte
			4'd8:
				data_c = MS_P3[15:8];
			4'd9:
				data_c = MS_P3[23:16];
			4'd10:
				data_c = {2'b00, MS_P3[29:24]};           // Upper two bits reserved
			default:
				data_c = 8'd0;                            // Idle or out of range
		endcase
	end

	assign byte_addr = addr_c;
	assign byte_data = data_c;

endmodule

//--- source/cfg_seq_pkg.sv
package cfg_seq_pkg;

	localparam int STEP_W = 4;                     // Enough for idle plus ten writes

	// Step index
	// 0 is idle, 1..LAST_STEP select one register write
	typedef logic [STEP_W-1:0] step_t;

	// Sequencer phases
	localparam step_t STEP_IDLE = step_t'(0);      // No run in progress
	localparam step_t FIRST_STEP = step_t'(1);     // Loaded on enable

	// One step per byte of the parameter block
	localparam step_t LAST_STEP = step_t'(si5338_reg_pkg::MS_REG_COUNT);

endpackage

//--- source/si5338_reg_pkg.sv
package si5338_reg_pkg;

	// Every address and data byte on the I2C side
	typedef logic [7:0] reg_byte_t;

	// ===========================================================================
	// MultiSynth divider field widths
	// ===========================================================================

	// P1 integer part of the divider
	localparam int MS_P1_W = 18;

	// P2 numerator and P3 denominator share one width
	localparam int MS_P23_W = 30;

	// ===========================================================================
	// Parameter block layout
	// ===========================================================================

	// Bytes in one MSx_P1/P2/P3 block
	// P1 takes bytes 1..2 plus two bits of byte 3
	// P2 takes the rest of byte 3 up to byte 6
	// P3 takes bytes 7..10 with two spare bits on top
	localparam int MS_REG_COUNT = 10;

	// First register of the MultiSynth 2 block (MS2_P1[7:0])
	// Other blocks sit at 53 (MS0), 64 (MS1) and 86 (MS3)
	localparam reg_byte_t MS2_BASE_ADDR = 8'd75;

endpackage
